/* core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;
	typedef logic [3:0]  reg_num;
	typedef logic [4:0]  psr_mode;

	localparam psr_mode MODE_SVC = 5'b10011;

	// data-processing opcodes in their instruction encoding order.
	typedef enum logic [3:0] {
		ALU_AND,
		ALU_EOR,
		ALU_SUB,
		ALU_RSB,
		ALU_ADD,
		ALU_ADC,
		ALU_SBC,
		ALU_RSC,
		ALU_TST,
		ALU_TEQ,
		ALU_CMP,
		ALU_CMN,
		ALU_ORR,
		ALU_MOV,
		ALU_BIC,
		ALU_MVN
	} alu_op;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		logic       is_imm;
		logic [7:0] imm;
		reg_num     r;
		reg_num     r_shift;
		logic       shift_by_reg;
		logic [5:0] shift_imm;   // one bit wider so that LSR and ASR #32 fit.
		logic       shl;
		logic       shr;
		logic       ror;
		logic       sign_extend;
		logic       put_carry;
	} snd_decode;

	typedef struct packed {
		alu_op  op;
		reg_num rn;
		reg_num rd;
	} data_decode;

	typedef struct packed {
		logic shl;
		logic shr;
		logic ror;
		logic put_carry;
		logic sign_extend;
	} shifter_control;

endpackage

/* core_dec_if.sv */
interface dec_if;

	logic                 execute;
	logic                 branch;
	logic                 writeback;
	logic                 update_flags;
	core_pkg::ptr         branch_offset;
	core_pkg::snd_decode  snd;
	core_pkg::data_decode data;

	modport decode (
		output execute,
		output branch,
		output writeback,
		output update_flags,
		output branch_offset,
		output snd,
		output data
	);

	modport seq (
		input execute,
		input branch,
		input writeback,
		input update_flags,
		input branch_offset,
		input snd,
		input data
	);

endinterface

/* core_decode.sv */
module core_decode (
	input  core_pkg::word insn,
	input  logic          insn_valid,
	input  logic          stall,
	dec_if.decode         dec
);

	logic           is_data;
	logic           reg_op;
	logic           is_logical;
	logic           is_test;
	core_pkg::alu_op op;

	always_comb begin
		is_data = insn[27:26] == 2'b00;
		reg_op = is_data & ~insn[25]; // register second operand.
		op = core_pkg::alu_op'(insn[24:21]);

		is_logical = 1'b0;
		case (op)
			core_pkg::ALU_AND, core_pkg::ALU_EOR, core_pkg::ALU_TST, core_pkg::ALU_TEQ,
			core_pkg::ALU_ORR, core_pkg::ALU_MOV, core_pkg::ALU_BIC, core_pkg::ALU_MVN:
				is_logical = 1'b1;
			default: ;
		endcase

		is_test = op inside {core_pkg::ALU_TST, core_pkg::ALU_TEQ,
			core_pkg::ALU_CMP, core_pkg::ALU_CMN};

		dec.execute = insn_valid & ~stall;
		dec.branch = insn[27:25] == 3'b101;
		dec.writeback = is_data & ~is_test & (insn[15:12] != 4'd15); // r15 writes are dropped.
		dec.update_flags = is_data & insn[20];
		dec.branch_offset = {{6{insn[23]}}, insn[23:0]};

		dec.data.op = op;
		dec.data.rn = insn[19:16];
		dec.data.rd = insn[15:12];

		dec.snd.is_imm = insn[25];
		dec.snd.imm = insn[7:0]; // the rotate field is ignored.
		dec.snd.r = insn[3:0];
		dec.snd.r_shift = insn[11:8];
		dec.snd.shift_by_reg = reg_op & insn[4];
		dec.snd.shl = reg_op & (insn[6:5] == 2'b00);
		dec.snd.shr = reg_op & ((insn[6:5] == 2'b01) | (insn[6:5] == 2'b10));
		dec.snd.sign_extend = reg_op & (insn[6:5] == 2'b10);
		dec.snd.ror = reg_op & (insn[6:5] == 2'b11);
		dec.snd.put_carry = is_logical;

		// an immediate amount of zero means 32 for LSR and ASR. ROR #0 is left unshifted.
		dec.snd.shift_imm = 6'd0;
		if (reg_op & ~insn[4]) begin
			dec.snd.shift_imm = {1'b0, insn[11:7]};
			if ((insn[11:7] == 5'd0) & insn[6:5] != 2'b00 & insn[6:5] != 2'b11)
				dec.snd.shift_imm = 6'd32;
		end
	end

endmodule

/* core_cycles.sv */
module core_cycles (
	input  logic                     clk,
	input  logic                     rst_n,
	dec_if.seq                       dec,
	input  core_pkg::ptr             fetch_insn_pc,
	input  core_pkg::psr_flags       next_flags,
	input  core_pkg::word            rd_value_b,
	input  core_pkg::word            q_alu,
	input  core_pkg::word            q_shifter,
	input  logic                     c_shifter,

	output logic                     stall,
	output logic                     branch,
	output logic                     writeback,
	output logic                     update_flags,
	output logic                     c_in,
	output core_pkg::reg_num         rd,
	output core_pkg::reg_num         ra,
	output core_pkg::reg_num         rb,
	output core_pkg::ptr             branch_target,
	output core_pkg::ptr             pc_visible,
	output core_pkg::psr_mode        reg_mode,
	output core_pkg::alu_op          alu,
	output core_pkg::word            alu_b,
	output core_pkg::word            wr_value,
	output core_pkg::shifter_control shifter,
	output logic [7:0]               shifter_shift
);

	typedef enum logic [1:0] {
		EXECUTE,
		RD_INDIRECT_SHIFT,
		WITH_SHIFT
	} cycle_t;

	cycle_t           cycle, next_cycle;
	logic             bubble, hazard, retire, active, trivial_shift;
	logic             final_writeback, final_update_flags, final_branch;
	logic             snd_is_imm, snd_shift_by_reg;
	logic [7:0]       snd_imm;
	logic [5:0]       snd_shift_imm;
	core_pkg::word    saved_base;
	core_pkg::reg_num r_shift, final_rd;
	core_pkg::ptr     pc, branch_offset;

	assign reg_mode = core_pkg::MODE_SVC;
	assign pc_visible = pc + 30'd2;
	assign stall = (next_cycle != EXECUTE) | bubble;

	// the captured instruction is done when the next cycle starts over.
	assign active = final_writeback | final_update_flags;
	assign retire = (next_cycle == EXECUTE) & ~bubble;
	assign update_flags = final_update_flags & retire;
	assign branch = final_branch & retire;
	assign branch_target = pc_visible + branch_offset;

	// the pending rd reaches the register file one cycle too late for its successor.
	assign hazard = (final_update_flags & dec.update_flags)
		| (final_writeback & ((final_rd == dec.data.rn)
			| (~dec.snd.is_imm & (final_rd == dec.snd.r))));

	//////////////////////////////////////////////////////////////////////
	// next cycle and operand selection.
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (cycle == RD_INDIRECT_SHIFT)
			shifter_shift = rd_value_b[7:0]; // rb now points at the shift register.
		else
			shifter_shift = {2'b00, snd_shift_imm};

		trivial_shift = ~(shifter.shl | shifter.shr | shifter.ror) | (shifter_shift == 8'd0);

		next_cycle = EXECUTE;
		case (cycle)
			EXECUTE:
				if (active & snd_shift_by_reg)
					next_cycle = RD_INDIRECT_SHIFT;
				else if (active & ~trivial_shift)
					next_cycle = WITH_SHIFT;
			RD_INDIRECT_SHIFT:
				if (~trivial_shift)
					next_cycle = WITH_SHIFT;
			default: ;
		endcase

		if (bubble)
			next_cycle = EXECUTE;

		if (cycle != EXECUTE)
			alu_b = saved_base;
		else if (snd_is_imm)
			alu_b = {24'd0, snd_imm};
		else
			alu_b = rd_value_b;
	end

	//////////////////////////////////////////////////////////////////////
	// control state.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= EXECUTE;
			bubble <= 1'b1; // keeps fetch off for the first cycle.
			writeback <= 1'b0;
			c_in <= 1'b0;
			final_writeback <= 1'b0;
			final_update_flags <= 1'b0;
			final_branch <= 1'b0;
		end else begin
			cycle <= next_cycle;
			writeback <= 1'b0;

			if (bubble) begin
				bubble <= 1'b0; // the held instruction computes next cycle.
			end else if (next_cycle == EXECUTE) begin
				writeback <= final_writeback;
				final_writeback <= dec.execute & dec.writeback;
				final_update_flags <= dec.execute & dec.update_flags;
				final_branch <= dec.execute & dec.branch;
				bubble <= dec.execute & hazard;
				if (dec.execute)
					c_in <= next_flags.c; // includes the flags of the retiring instruction.
			end else if (next_cycle == WITH_SHIFT) begin
				c_in <= c_shifter;
			end
		end
	end

	// instruction fields and datapath registers.
	always_ff @(posedge clk) begin
		wr_value <= q_alu;

		if (!bubble) begin
			case (next_cycle)
				EXECUTE: begin
					rd <= final_rd;
					if (dec.execute) begin
						alu <= dec.data.op;
						ra <= dec.data.rn;
						rb <= dec.snd.r;
						r_shift <= dec.snd.r_shift;
						final_rd <= dec.data.rd;
						snd_is_imm <= dec.snd.is_imm;
						snd_shift_by_reg <= dec.snd.shift_by_reg;
						snd_imm <= dec.snd.imm;
						snd_shift_imm <= dec.snd.shift_imm;
						shifter.shl <= dec.snd.shl;
						shifter.shr <= dec.snd.shr;
						shifter.ror <= dec.snd.ror;
						shifter.put_carry <= dec.snd.put_carry;
						shifter.sign_extend <= dec.snd.sign_extend;
						branch_offset <= dec.branch_offset;
						pc <= fetch_insn_pc;
					end
				end
				RD_INDIRECT_SHIFT: begin
					saved_base <= rd_value_b;
					rb <= r_shift;
				end
				WITH_SHIFT: saved_base <= q_shifter;
				default: ;
			endcase
		end
	end

endmodule

/* core_regfile.sv */
module core_regfile #(
	parameter int REG_COUNT = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  core_pkg::reg_num  ra,
	input  core_pkg::reg_num  rb,
	input  core_pkg::ptr      pc_visible,
	input  core_pkg::psr_mode reg_mode,
	input  logic              we,
	input  core_pkg::reg_num  wd_rd,
	input  core_pkg::word     wd,
	output core_pkg::word     rd_value_a,
	output core_pkg::word     rd_value_b
);

	localparam core_pkg::reg_num PC_REG = core_pkg::reg_num'(REG_COUNT - 1);

	core_pkg::word regs [REG_COUNT];
	core_pkg::word pc_word;

	assign pc_word = {pc_visible, 2'b00};
	assign rd_value_a = (ra == PC_REG) ? pc_word : regs[ra];
	assign rd_value_b = (rb == PC_REG) ? pc_word : regs[rb];

	// every 32-bit mode (bit 4 set) shares one bank for now.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we & reg_mode[4] & (wd_rd != PC_REG)) begin
			regs[wd_rd] <= wd;
		end
	end

endmodule

/* core_shifter.sv */
module core_shifter (
	input  core_pkg::word            base,
	input  logic [7:0]               shift,
	input  core_pkg::shifter_control ctrl,
	input  logic                     c_in,
	output core_pkg::word            q,
	output logic                     c_out
);

	logic [32:0] wide_l; // carry out sits in bit 32.
	logic [32:0] wide_r; // carry out sits in bit 0.
	logic [63:0] rot;
	logic        carry;

	always_comb begin
		wide_l = {1'b0, base} << shift;
		if (ctrl.sign_extend)
			wide_r = $signed({base, 1'b0}) >>> shift;
		else
			wide_r = {base, 1'b0} >> shift;

		// rotation only looks at the low five bits. a multiple of 32 leaves base as is.
		rot = {base, base} >> shift[4:0];

		q = base;
		carry = c_in;
		if (shift != 8'd0) begin
			if (ctrl.shl) begin
				q = wide_l[31:0];
				carry = wide_l[32];
			end else if (ctrl.shr) begin
				q = wide_r[32:1];
				carry = wide_r[0];
			end else if (ctrl.ror) begin
				q = rot[31:0];
				carry = rot[31];
			end
		end

		c_out = ctrl.put_carry ? carry : c_in; // arithmetic opcodes keep the flag carry.
	end

endmodule

/* core_alu.sv */
module core_alu (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::alu_op    op,
	input  core_pkg::word      a,
	input  core_pkg::word      b,
	input  logic               c_in,
	input  logic               update_flags,
	output core_pkg::word      q,
	output core_pkg::psr_flags next_flags,
	output core_pkg::psr_flags flags
);

	core_pkg::word      x, y;
	logic               cy, logical;
	logic [32:0]        sum;
	core_pkg::psr_flags result_flags;

	always_comb begin
		x = a;
		y = b;
		cy = 1'b0;
		logical = 1'b1;
		q = '0;

		case (op)
			core_pkg::ALU_AND, core_pkg::ALU_TST: q = a & b;
			core_pkg::ALU_EOR, core_pkg::ALU_TEQ: q = a ^ b;
			core_pkg::ALU_ORR:                    q = a | b;
			core_pkg::ALU_MOV:                    q = b;
			core_pkg::ALU_BIC:                    q = a & ~b;
			core_pkg::ALU_MVN:                    q = ~b;
			default:                              logical = 1'b0;
		endcase

		// subtraction is an add of the inverted operand.
		case (op)
			core_pkg::ALU_SUB, core_pkg::ALU_CMP: begin
				y = ~b;
				cy = 1'b1;
			end
			core_pkg::ALU_RSB: begin
				x = b;
				y = ~a;
				cy = 1'b1;
			end
			core_pkg::ALU_ADC: cy = c_in;
			core_pkg::ALU_SBC: begin
				y = ~b;
				cy = c_in;
			end
			core_pkg::ALU_RSC: begin
				x = b;
				y = ~a;
				cy = c_in;
			end
			default: ;
		endcase

		sum = {1'b0, x} + {1'b0, y} + {32'd0, cy};
		if (!logical)
			q = sum[31:0];

		result_flags.n = q[31];
		result_flags.z = q == '0;
		result_flags.c = logical ? c_in : sum[32];
		result_flags.v = logical ? flags.v : (x[31] == y[31]) & (sum[31] != x[31]);

		next_flags = update_flags ? result_flags : flags;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

/* core_top.sv */
module core_top #(
	parameter int REG_COUNT = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::word      insn,
	input  core_pkg::ptr       insn_pc,
	input  logic               insn_valid,
	output logic               insn_ready,
	output logic               wb_valid,
	output core_pkg::reg_num   wb_rd,
	output core_pkg::word      wb_value,
	output core_pkg::psr_flags flags,
	output logic               branch_valid,
	output core_pkg::ptr       branch_target
);

	logic                     stall, branch, writeback, update_flags, c_in, c_shifter;
	core_pkg::reg_num         rd, ra, rb;
	core_pkg::ptr             seq_target, pc_visible;
	core_pkg::psr_mode        reg_mode;
	core_pkg::alu_op          alu;
	core_pkg::word            alu_b, wr_value, rd_value_a, rd_value_b, q_alu, q_shifter;
	core_pkg::shifter_control shifter;
	logic [7:0]               shifter_shift;
	core_pkg::psr_flags       next_flags;

	dec_if dec_i ();

	assign insn_ready = ~stall;
	assign wb_valid = writeback;
	assign wb_rd = rd;
	assign wb_value = wr_value;

	// branch results line up with the writeback pulse of a data instruction.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			branch_valid <= 1'b0;
			branch_target <= '0;
		end else begin
			branch_valid <= branch;
			branch_target <= seq_target;
		end
	end

	core_decode decode_i (
		.insn,
		.insn_valid,
		.stall,
		.dec (dec_i.decode)
	);

	core_cycles cycles_i (
		.clk,
		.rst_n,
		.dec           (dec_i.seq),
		.fetch_insn_pc (insn_pc),
		.next_flags,
		.rd_value_b,
		.q_alu,
		.q_shifter,
		.c_shifter,
		.stall,
		.branch,
		.writeback,
		.update_flags,
		.c_in,
		.rd,
		.ra,
		.rb,
		.branch_target (seq_target),
		.pc_visible,
		.reg_mode,
		.alu,
		.alu_b,
		.wr_value,
		.shifter,
		.shifter_shift
	);

	core_regfile #(.REG_COUNT(REG_COUNT)) regfile_i (
		.clk,
		.rst_n,
		.ra,
		.rb,
		.pc_visible,
		.reg_mode,
		.we    (writeback),
		.wd_rd (rd),
		.wd    (wr_value),
		.rd_value_a,
		.rd_value_b
	);

	core_shifter shifter_i (
		.base  (alu_b),
		.shift (shifter_shift),
		.ctrl  (shifter),
		.c_in,
		.q     (q_shifter),
		.c_out (c_shifter)
	);

	core_alu alu_i (
		.clk,
		.rst_n,
		.op (alu),
		.a  (rd_value_a),
		.b  (alu_b),
		.c_in,
		.update_flags,
		.q  (q_alu),
		.next_flags,
		.flags
	);

endmodule

/* tb_core.sv */
module tb_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LOAD_COUNT = 30;
	localparam int OP_REPS = 4;
	localparam int SHIFT_COUNT = 60;
	localparam int CHAIN_COUNT = 16;
	localparam int BRANCH_COUNT = 8;
	localparam int INSN_COUNT = 15 + LOAD_COUNT + 20 * OP_REPS + 2 * SHIFT_COUNT
		+ CHAIN_COUNT + BRANCH_COUNT + 8;
	localparam int CYCLE_LIMIT = 4 * INSN_COUNT + 100;

	logic               clk, rst_n, insn_valid, insn_ready;
	core_pkg::word      insn, wb_value;
	core_pkg::ptr       insn_pc, branch_target;
	logic               wb_valid, branch_valid;
	core_pkg::reg_num   wb_rd;
	core_pkg::psr_flags flags;

	core_pkg::word      model_regs [15];
	core_pkg::psr_flags model_flags;
	core_pkg::ptr       next_pc;
	logic [31:0]        lcg_state;
	int                 value_errors, other_errors, cycles;
	string              test_name;

	// one entry per pulse the DUT must produce, in program order.
	logic               exp_branch [$];
	core_pkg::reg_num   exp_rd [$];
	logic [31:0]        exp_val [$];
	core_pkg::psr_flags exp_flags [$];
	string              exp_name [$];

	core_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[30:16], lcg_state[15:0] ^ lcg_state[31:16], 1'b0} ^ lcg_state;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model.
	//////////////////////////////////////////////////////////////////////

	function automatic core_pkg::word read_reg(input core_pkg::reg_num r, input core_pkg::ptr pc);
		core_pkg::ptr seen;
		seen = pc + 30'd2;
		if (r == 4'd15)
			return {seen, 2'b00};
		return model_regs[r];
	endfunction

	// one bit per step, the way the ARM rules describe each shift.
	function automatic void shift_operand(input logic [1:0] kind, input int amt,
			inout core_pkg::word b, inout logic c);
		for (int i = 0; i < amt; i++) begin
			case (kind)
				2'd0: begin
					c = b[31];
					b = {b[30:0], 1'b0};
				end
				2'd1: begin
					c = b[0];
					b = {1'b0, b[31:1]};
				end
				2'd2: begin
					c = b[0];
					b = {b[31], b[31:1]};
				end
				default: begin
					c = b[0];
					b = {b[0], b[31:1]};
				end
			endcase
		end
	endfunction

	function automatic void add_with_carry(input core_pkg::word x, input core_pkg::word y,
			input logic cin, output core_pkg::word res, output logic c, output logic v);
		longint unsigned usum;
		longint          ssum;
		usum = longint'(x) + longint'(y) + longint'(cin);
		ssum = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
		res = usum[31:0];
		c = usum[32];
		v = ssum != longint'($signed(res)); // signed result does not fit in 32 bits.
	endfunction

	function automatic void execute_model(input core_pkg::word w, input core_pkg::ptr pc,
			output logic wb, output logic br, output core_pkg::word val, output core_pkg::ptr tgt);
		core_pkg::word a, b, res;
		logic          sc, c, v, logical;
		int            amt;
		logic [3:0]    op;
		wb = 1'b0;
		br = 1'b0;
		val = '0;
		tgt = '0;
		if (w[27:25] == 3'b101) begin
			br = 1'b1;
			tgt = pc + 30'd2 + {{6{w[23]}}, w[23:0]};
			return;
		end
		op = w[24:21];
		a = read_reg(w[19:16], pc);
		sc = model_flags.c;
		c = model_flags.c;
		v = model_flags.v;
		if (w[25]) begin
			b = {24'd0, w[7:0]};
		end else begin
			b = read_reg(w[3:0], pc);
			if (w[4]) begin
				amt = int'(read_reg(w[11:8], pc) & 32'hff);
			end else begin
				amt = int'(w[11:7]);
				if (amt == 0 && (w[6:5] == 2'd1 || w[6:5] == 2'd2))
					amt = 32;
			end
			shift_operand(w[6:5], amt, b, sc);
		end
		logical = op inside {4'd0, 4'd1, 4'd8, 4'd9, 4'd12, 4'd13, 4'd14, 4'd15};
		case (op)
			4'd0, 4'd8: res = a & b;
			4'd1, 4'd9: res = a ^ b;
			4'd2, 4'd10: add_with_carry(a, ~b, 1'b1, res, c, v);
			4'd3: add_with_carry(b, ~a, 1'b1, res, c, v);
			4'd4, 4'd11: add_with_carry(a, b, 1'b0, res, c, v);
			4'd5: add_with_carry(a, b, model_flags.c, res, c, v);
			4'd6: add_with_carry(a, ~b, model_flags.c, res, c, v);
			4'd7: add_with_carry(b, ~a, model_flags.c, res, c, v);
			4'd12: res = a | b;
			4'd13: res = b;
			4'd14: res = a & ~b;
			default: res = ~b;
		endcase
		if (logical)
			c = sc;
		if (w[20])
			model_flags = '{n: res[31], z: res == '0, c: c, v: v};
		val = res;
		wb = !(op inside {[4'd8:4'd11]}) && w[15:12] != 4'd15;
		if (wb)
			model_regs[w[15:12]] = res;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// encoders and the fetch side.
	//////////////////////////////////////////////////////////////////////

	function automatic core_pkg::word dp_imm(input int op, input logic s, input int rn,
			input int rd, input logic [7:0] imm);
		return 32'he2000000 | (op << 21) | (32'(s) << 20) | (rn << 16) | (rd << 12) | 32'(imm);
	endfunction

	function automatic core_pkg::word dp_reg(input int op, input logic s, input int rn, input int rd,
			input int amt, input int kind, input int rm);
		return 32'he0000000 | (op << 21) | (32'(s) << 20) | (rn << 16) | (rd << 12)
			| (amt << 7) | (kind << 5) | rm;
	endfunction

	function automatic core_pkg::word dp_rsr(input int op, input logic s, input int rn, input int rd,
			input int rs, input int kind, input int rm);
		return 32'he0000010 | (op << 21) | (32'(s) << 20) | (rn << 16) | (rd << 12)
			| (rs << 8) | (kind << 5) | rm;
	endfunction

	task automatic issue(input core_pkg::word w);
		logic          wb, br;
		core_pkg::word val;
		core_pkg::ptr  tgt;
		execute_model(w, next_pc, wb, br, val, tgt);
		if (wb || br) begin
			exp_branch.push_back(br);
			exp_rd.push_back(w[15:12]);
			exp_val.push_back(br ? 32'(tgt) : val);
			exp_flags.push_back(model_flags);
			exp_name.push_back(test_name);
		end
		insn <= w;
		insn_pc <= next_pc;
		insn_valid <= 1'b1;
		do @(negedge clk); while (!insn_ready); // held stable until the DUT takes it.
		@(posedge clk);
		next_pc = next_pc + 30'd1;
	endtask

	function automatic int pick_amount(input logic by_reg);
		logic [31:0] r;
		r = next_random();
		case (r[1:0])
			2'd0: return 0;
			2'd1: return 1 + int'(r[15:8] % 31);
			2'd2: return by_reg ? 32 : 31;
			default: return by_reg ? 33 + int'(r[15:8] % 223) : 1 + int'(r[20:16] % 31);
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checker.
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n && (wb_valid || branch_valid)) begin
			if (exp_branch.size() == 0) begin
				$display("a result pulse arrived with no instruction pending");
				other_errors++;
			end else if (exp_branch[0] != branch_valid || wb_valid == branch_valid) begin
				$display("%s: the DUT pulsed the wrong kind of result", exp_name[0]);
				other_errors++;
			end else begin
				if (wb_valid && wb_rd != exp_rd[0]) begin
					$display("** Error %s: rd expected %0d actual %0d", exp_name[0], exp_rd[0], wb_rd);
					value_errors++;
				end
				if (wb_valid && wb_value != exp_val[0]) begin
					$display("** Error %s: value expected %h actual %h", exp_name[0], exp_val[0],
						wb_value);
					value_errors++;
				end
				if (branch_valid && 32'(branch_target) != exp_val[0]) begin
					$display("** Error %s: target expected %h actual %h", exp_name[0], exp_val[0],
						branch_target);
					value_errors++;
				end
				if (flags != exp_flags[0]) begin
					$display("** Error %s: flags expected %b actual %b", exp_name[0], exp_flags[0],
						flags);
					value_errors++;
				end
			end
			if (exp_branch.size() != 0) begin
				void'(exp_branch.pop_front());
				void'(exp_rd.pop_front());
				void'(exp_val.pop_front());
				void'(exp_flags.pop_front());
				void'(exp_name.pop_front());
			end
		end
	end

	initial begin
		logic [31:0] r;
		int          amt;
		rst_n = 1'b0;
		insn = '0;
		insn_pc = '0;
		insn_valid = 1'b0;
		cycles = 0;
		value_errors = 0;
		other_errors = 0;
		lcg_state = 32'd30159;
		next_pc = 30'h100;
		model_flags = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (flags != 4'b0000) begin
			$display("** Error reset: flags expected 0000 actual %b", flags);
			value_errors++;
		end
		@(posedge clk);

		test_name = "reset";
		for (int i = 0; i < 15; i++)
			issue(dp_reg(13, 1'b0, 0, i, 0, 0, i));

		test_name = "load";
		for (int i = 0; i < 15; i++) begin
			r = next_random();
			issue(dp_imm((i % 2) ? 15 : 13, 1'b0, 0, i, r[7:0]));
			issue(dp_reg(1, r[8], i, i, 1 + int'(r[15:11] % 31), 3, i));
		end

		test_name = "opcodes";
		for (int op = 0; op < 16; op++) begin
			for (int k = 0; k < OP_REPS; k++) begin
				r = next_random();
				issue(dp_imm(op, (op >= 8 && op <= 11) | r[8], int'(r[12:9] % 15),
					int'(r[19:16] % 15), r[7:0]));
				if (op >= 8 && op <= 11)
					issue(dp_imm(13, 1'b0, 0, 14, r[7:0])); // shows the compare flags.
			end
		end

		test_name = "shifts";
		for (int k = 0; k < SHIFT_COUNT; k++) begin
			r = next_random();
			if (r[0]) begin
				amt = pick_amount(1'b1);
				issue(dp_imm(13, 1'b0, 0, int'(r[8:5] % 15), 8'(amt)));
				issue(dp_rsr(int'(r[12:9]), r[13], int'(r[17:14] % 15), int'(r[21:18] % 15),
					int'(r[8:5] % 15), int'(r[23:22]), int'(r[27:24] % 15)));
			end else begin
				amt = pick_amount(1'b0);
				issue(dp_reg(int'(r[12:9]), r[13], int'(r[17:14] % 15), int'(r[21:18] % 15),
					amt, int'(r[23:22]), int'(r[27:24] % 15)));
			end
		end

		test_name = "hazards";
		for (int k = 0; k < CHAIN_COUNT; k++) begin
			r = next_random();
			issue(dp_reg(2 + int'(r[2:0] % 6), 1'b1, 1, 1, 0, 0, int'(r[7:4] % 15)));
		end

		test_name = "branch";
		for (int k = 0; k < BRANCH_COUNT; k++) begin
			r = next_random();
			issue(32'hea000000 | {8'd0, r[23:0]});
		end

		test_name = "r15";
		issue(dp_imm(4, 1'b0, 15, 0, 8'd0));
		issue(dp_reg(13, 1'b0, 0, 1, 0, 0, 15));
		issue(dp_imm(13, 1'b0, 0, 15, 8'd5));
		issue(dp_imm(10, 1'b1, 0, 0, 8'd1));
		issue(dp_imm(8, 1'b1, 1, 0, 8'hff));
		issue(dp_imm(9, 1'b1, 2, 0, 8'h3c));
		issue(dp_imm(11, 1'b1, 3, 0, 8'h80));
		issue(dp_reg(4, 1'b1, 15, 2, 0, 0, 15));
		insn_valid <= 1'b0;

		while (exp_branch.size() != 0)
			@(negedge clk);
		repeat (10) @(negedge clk); // catches any stray pulse after the last one.

		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* src.f */
core_pkg.sv
core_dec_if.sv
core_decode.sv
core_cycles.sv
core_regfile.sv
core_shifter.sv
core_alu.sv
core_top.sv
tb_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_core
FILELIST  := src.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
